// ==== filelist.f ====
+incdir+include
src/uart_link_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/seq_checker.sv
src/uart_link_top.sv
tb/tb_uart_link.sv

// ==== tb/uart_link_stim.txt ====
// columns: data byte, corruption (0 none, 1 parity flipped, 2 stop bit low),
// idle gap in bit times, error count expected after the frame; all hex
00 0 02 00
01 0 02 00
02 0 02 00
03 0 02 00
04 0 02 00
05 0 10 00
40 0 10 01
07 0 02 01
08 0 10 01
09 1 10 02
0a 0 10 02
0b 2 10 03
0c 0 02 03
0d 0 10 03
80 0 00 04
0f 1 00 05
90 0 00 06
11 2 01 07
22 0 00 08
13 1 10 09
14 0 02 09
15 0 02 09
16 0 02 09
17 0 02 09
18 0 02 09
19 0 02 09
1a 0 02 09
1b 0 02 09
1c 0 02 09
1d 0 10 09

// ==== tb/tb_uart_link.sv ====
// testbench for the uart link test block driving file based serial frames and decoding error reports
`timescale 1ns/1ps

module tb_uart_link;

    localparam int CLKS_PER_BIT = 8;
    localparam int NUM_FRAMES   = 30;                   // data lines in the stim file
    localparam int CKPT_GAP     = 16;                   // gap that leaves room for a report
    localparam int QUIET_CYCLES = 12 * CLKS_PER_BIT;    // idle time that ends a report burst
    localparam int QUIET_LIMIT  = 4000;                 // cycles

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        tx;
    logic        led_ok;
    logic        led_err;

    logic [7:0]  stim_mem [0:4*NUM_FRAMES-1];   // four fields per frame
    logic [7:0]  reports [$];                   // every byte decoded from tx
    logic [7:0]  last_report;
    logic        mon_busy;                      // monitor inside a frame
    logic [31:0] lfsr_state;
    logic [7:0]  ckpt_cnt;                      // error count at the last checkpoint
    int          ckpt_reports;                  // reports seen at the last checkpoint
    int          mismatch_cnt;
    int          fail_cnt;

    uart_link_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (uart_link_pkg::PARITY_EVEN)
    ) u_uart_link_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .tx           (tx),
        .led_ok       (led_ok),
        .led_err      (led_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 0 to 3 extra idle bits from one lfsr step per bit
    task automatic draw_jitter(output int bits);
        bits = 0;
        repeat (2) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = (bits << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            mismatch_cnt++;
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d value mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    // one bit time on rx driven just after the edge
    task automatic send_bit(input logic b);
        @(posedge clk);
        #1 rx = b;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic [7:0] kind);
        logic par;
        par = ^data;                    // even parity
        if (kind == 8'd1)
            par = ~par;                 // corrupt parity
        send_bit(1'b0);
        for (int i = 0; i < 8; i++)
            send_bit(data[i]);          // lsb first
        send_bit(par);
        send_bit(kind != 8'd2);         // stop low for kind 2
    endtask

    // called on the first low sample and returns at mid stop bit
    task automatic decode_report();
        logic [7:0] data;
        logic       par;
        mon_busy = 1'b1;
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            fail_cnt++;
            $display("tx start bit went high again before mid-bit at %0t", $time);
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        par = tx;
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (par !== ^data) begin
            fail_cnt++;
            $display("report frame on tx has wrong parity at %0t", $time);
        end
        if (tx !== 1'b1) begin
            fail_cnt++;
            $display("report frame on tx has no stop bit at %0t", $time);
        end
        if (reports.size() > 0 && data <= reports[$]) begin
            fail_cnt++;
            $display("report %0d at %0t is not above the previous report %0d",
                     data, $time, reports[$]);
        end
        reports.push_back(data);
        last_report = data;
        mon_busy    = 1'b0;
    endtask

    initial begin : tx_monitor
        mon_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx === 1'b0)
                decode_report();
        end
    end

    // bounded wait for tx high with the monitor idle
    task automatic wait_tx_quiet(output logic quiet_ok);
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES && waited < QUIET_LIMIT) begin
            @(negedge clk);
            waited++;
            quiet = (tx === 1'b1 && !mon_busy) ? quiet + 1 : 0;
        end
        quiet_ok = (quiet >= QUIET_CYCLES);
        if (!quiet_ok) begin
            fail_cnt++;
            $display("timeout: tx line never went quiet within %0d cycles", QUIET_LIMIT);
        end
    endtask

    // reports and leds since the last checkpoint
    task automatic checkpoint(input int frame_idx, input logic [7:0] exp_cnt,
                              output logic quiet_ok);
        int new_reports;
        wait_tx_quiet(quiet_ok);
        if (quiet_ok) begin
            new_reports = reports.size() - ckpt_reports;
            if (exp_cnt == ckpt_cnt) begin
                check_value("report_frames", 0, new_reports);   // clean bytes stay silent
            end else if (new_reports == 0) begin
                fail_cnt++;
                $display("no report on tx after frame %0d, error count %0d expected",
                         frame_idx, exp_cnt);
            end else begin
                if (exp_cnt == ckpt_cnt + 1)
                    check_value("report_frames", 1, new_reports);
                check_value("tx_report", exp_cnt, last_report);  // latest count wins
            end
            check_value("led_ok", exp_cnt == 0, led_ok);
            check_value("led_err", exp_cnt != 0, led_err);
            ckpt_reports = reports.size();
            ckpt_cnt     = exp_cnt;
        end
    endtask

    initial begin : main_seq
        logic [7:0] data;
        logic [7:0] kind;
        logic [7:0] gap;
        logic [7:0] exp_cnt;
        logic       ckpt_ok;
        int         jitter;
        rst_n        = 1'b0;
        rx           = 1'b1;        // line idle
        mismatch_cnt = 0;
        fail_cnt     = 0;
        lfsr_state   = 32'hdb3e5e11;
        ckpt_reports = 0;
        ckpt_cnt     = 8'd0;
        $readmemh("tb/uart_link_stim.txt", stim_mem);
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("tx", 1, tx);
        check_value("led_ok", 1, led_ok);
        check_value("led_err", 0, led_err);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            data    = stim_mem[4*f];
            kind    = stim_mem[4*f+1];
            gap     = stim_mem[4*f+2];
            exp_cnt = stim_mem[4*f+3];
            if ($isunknown({data, kind, gap, exp_cnt})) begin
                fail_cnt++;
                $display("stimulus line %0d is missing or unreadable", f);
                break;
            end
            send_frame(data, kind);
            jitter = 0;
            if (gap != 8'd0)
                draw_jitter(jitter);    // zero gap stays back to back
            repeat (gap + jitter)
                send_bit(1'b1);
            if (gap >= CKPT_GAP || f == NUM_FRAMES - 1) begin
                checkpoint(f, exp_cnt, ckpt_ok);
                if (!ckpt_ok)
                    break;              // tx stuck busy
            end
        end
        finish_run();
    end

endmodule

// ==== src/uart_link_top.sv ====
// uart link test top, receiver into sequence checker into transmitter
`timescale 1ns/1ps
`include "uart_baud.svh"

module uart_link_top #(
    parameter int                          CLKS_PER_BIT = `BAUD_1M_CLK48M,
    parameter uart_link_pkg::parity_mode_e PARITY       = uart_link_pkg::PARITY_NONE
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,        // serial from host
    output logic tx,        // serial to host
    output logic led_ok,
    output logic led_err
);

    logic [uart_link_pkg::DATA_W-1:0] rx_data;
    logic                             rx_done;
    logic                             parity_error;
    logic                             frame_error;
    logic [uart_link_pkg::DATA_W-1:0] tx_data;
    logic                             tx_start;
    logic                             tx_busy;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY)
    ) u_uart_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .rx_data      (rx_data),
        .rx_done      (rx_done),
        .parity_error (parity_error),
        .frame_error  (frame_error)
    );

    seq_checker u_seq_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_done      (rx_done),
        .parity_error (parity_error),
        .frame_error  (frame_error),
        .tx_busy      (tx_busy),
        .tx_data      (tx_data),
        .tx_start     (tx_start),
        .led_ok       (led_ok),
        .led_err      (led_err)
    );

    // same framing both directions
    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .PARITY       (PARITY)
    ) u_uart_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .tx           (tx),
        .tx_busy      (tx_busy)
    );

endmodule

// ==== src/seq_checker.sv ====
// sequence checker, compares bytes to a counting pattern and reports error counts over tx
`timescale 1ns/1ps

module seq_checker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [uart_link_pkg::DATA_W-1:0] rx_data,
    input  logic                             rx_done,
    input  logic                             parity_error,
    input  logic                             frame_error,
    input  logic                             tx_busy,
    output logic [uart_link_pkg::DATA_W-1:0] tx_data,
    output logic                             tx_start,
    output logic                             led_ok,
    output logic                             led_err
);

    localparam int DATA_W = uart_link_pkg::DATA_W;

    logic [DATA_W-1:0]          expected;   // next value of the counting sequence
    logic [DATA_W-1:0]          err_cnt;    // saturating
    logic                       pending;    // report owed to the host
    logic                       byte_err;
    logic                       cnt_full;
    uart_link_pkg::chk_state_e  state;

    // rx outputs are held until the next rx_done, so compare a cycle late
    assign byte_err = (rx_data != expected) | parity_error | frame_error;
    assign cnt_full = &err_cnt;

    // one-cycle start, only when tx is free
    assign tx_start = (state == uart_link_pkg::CHK_REPORT) & ~tx_busy;
    assign tx_data  = err_cnt;  // always the latest count

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_link_pkg::CHK_WAIT;
            expected <= '0;
            err_cnt  <= '0;
            pending  <= 1'b0;
            led_ok   <= 1'b1;
            led_err  <= 1'b0;
        end else begin
            case (state)
                uart_link_pkg::CHK_WAIT: begin
                    if (rx_done)
                        state <= uart_link_pkg::CHK_COMPARE;
                end
                uart_link_pkg::CHK_COMPARE: begin
                    expected <= expected + 1'b1;    // advances on every byte, wraps
                    if (byte_err) begin
                        if (!cnt_full)
                            err_cnt <= err_cnt + 1'b1;
                        pending <= 1'b1;
                        led_err <= 1'b1;    // sticky
                        led_ok  <= 1'b0;
                    end
                    // an older report may still be waiting on tx
                    state <= (byte_err || pending) ? uart_link_pkg::CHK_REPORT
                                                   : uart_link_pkg::CHK_WAIT;
                end
                uart_link_pkg::CHK_REPORT: begin
                    if (tx_start)
                        pending <= 1'b0;
                    // no back-pressure on rx, a new byte wins over waiting
                    if (rx_done)
                        state <= uart_link_pkg::CHK_COMPARE;
                    else if (tx_start)
                        state <= uart_link_pkg::CHK_WAIT;
                end
                default: state <= uart_link_pkg::CHK_WAIT;
            endcase
        end
    end

endmodule

// ==== src/uart_tx.sv ====
// uart transmitter, start/data/optional parity/stop framing with a busy flag
`timescale 1ns/1ps

module uart_tx #(
    parameter int                          CLKS_PER_BIT = 48,
    parameter uart_link_pkg::parity_mode_e PARITY       = uart_link_pkg::PARITY_NONE
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             tx_start,
    input  logic [uart_link_pkg::DATA_W-1:0] tx_data,
    output logic                             tx,
    output logic                             tx_busy
);

    localparam int DATA_W = uart_link_pkg::DATA_W;
    localparam int CNT_W  = $clog2(CLKS_PER_BIT);
    localparam int IDX_W  = $clog2(DATA_W);

    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

    logic                      accept;      // handshake taken this cycle
    logic                      par_bit;
    logic [DATA_W-1:0]         tx_byte;     // latched frame payload
    logic [CNT_W-1:0]          clk_cnt;     // bit timer
    logic [IDX_W-1:0]          bit_idx;
    logic [IDX_W-1:0]          next_idx;
    uart_link_pkg::tx_state_e  state;

    assign accept   = tx_start & ~tx_busy;
    assign next_idx = bit_idx + 1'b1;
    assign par_bit  = (^tx_byte) ^ (PARITY == uart_link_pkg::PARITY_ODD);

    always_ff @(posedge clk) begin
        if (accept)
            tx_byte <= tx_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_link_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;    // line idles high
            tx_busy <= 1'b0;
        end else begin
            case (state)
                uart_link_pkg::TX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (accept) begin
                        state   <= uart_link_pkg::TX_START;
                        tx      <= 1'b0;    // start bit begins with busy
                        tx_busy <= 1'b1;
                    end
                end
                uart_link_pkg::TX_START: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        state   <= uart_link_pkg::TX_DATA;
                        tx      <= tx_byte[0];
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::TX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        if (bit_idx == LAST_IDX) begin
                            if (PARITY != uart_link_pkg::PARITY_NONE) begin
                                state <= uart_link_pkg::TX_PARITY;
                                tx    <= par_bit;
                            end else begin
                                state <= uart_link_pkg::TX_STOP;
                                tx    <= 1'b1;
                            end
                        end else begin
                            bit_idx <= next_idx;
                            tx      <= tx_byte[next_idx];   // lsb first
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::TX_PARITY: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        state   <= uart_link_pkg::TX_STOP;
                        tx      <= 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::TX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        state   <= uart_link_pkg::TX_IDLE;
                        tx_busy <= 1'b0;    // full stop bit sent
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= uart_link_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

// ==== src/uart_rx.sv ====
// uart receiver, synchronised line, mid-bit sampling with parity and stop checks
`timescale 1ns/1ps

module uart_rx #(
    parameter int                          CLKS_PER_BIT = 48,
    parameter uart_link_pkg::parity_mode_e PARITY       = uart_link_pkg::PARITY_NONE
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rx,
    output logic [uart_link_pkg::DATA_W-1:0] rx_data,
    output logic                             rx_done,
    output logic                             parity_error,
    output logic                             frame_error
);

    localparam int DATA_W = uart_link_pkg::DATA_W;
    localparam int CNT_W  = $clog2(CLKS_PER_BIT);
    localparam int IDX_W  = $clog2(DATA_W);

    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1); // start to mid-bit
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

    logic                      rx_meta;     // first sync stage
    logic                      rx_sync;     // second sync stage, safe to use
    logic                      rx_sync_q;   // previous synced value for edge detect
    logic                      start_edge;
    logic                      par_calc;    // parity bit the data calls for
    logic                      par_bit;     // parity bit as received
    logic [DATA_W-1:0]         shift;
    logic [CNT_W-1:0]          clk_cnt;
    logic [IDX_W-1:0]          bit_idx;
    uart_link_pkg::rx_state_e  state;

    // line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta   <= 1'b1;
            rx_sync   <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta   <= rx;
            rx_sync   <= rx_meta;
            rx_sync_q <= rx_sync;
        end
    end

    assign start_edge = rx_sync_q & ~rx_sync;   // high to low
    assign par_calc   = (^shift) ^ (PARITY == uart_link_pkg::PARITY_ODD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= uart_link_pkg::RX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            rx_done      <= 1'b0;
            parity_error <= 1'b0;
            frame_error  <= 1'b0;
        end else begin
            rx_done <= 1'b0;    // single-cycle strobe
            case (state)
                uart_link_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge)
                        state <= uart_link_pkg::RX_START;
                end
                uart_link_pkg::RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch, not a real start bit
                        state   <= rx_sync ? uart_link_pkg::RX_IDLE : uart_link_pkg::RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_IDX)
                            state <= (PARITY == uart_link_pkg::PARITY_NONE) ?
                                     uart_link_pkg::RX_STOP : uart_link_pkg::RX_PARITY;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::RX_PARITY: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        state   <= uart_link_pkg::RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_link_pkg::RX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt      <= '0;
                        state        <= uart_link_pkg::RX_IDLE;
                        rx_done      <= 1'b1;
                        frame_error  <= ~rx_sync;   // stop must be high
                        parity_error <= (PARITY != uart_link_pkg::PARITY_NONE) &&
                                        (par_bit != par_calc);
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= uart_link_pkg::RX_IDLE;
            endcase
        end
    end

    // payload path, sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == uart_link_pkg::RX_DATA && clk_cnt == FULL_BIT)
            shift <= {rx_sync, shift[DATA_W-1:1]};  // lsb arrives first
        if (state == uart_link_pkg::RX_PARITY && clk_cnt == FULL_BIT)
            par_bit <= rx_sync;
        if (state == uart_link_pkg::RX_STOP && clk_cnt == FULL_BIT)
            rx_data <= shift;   // held until next frame
    end

endmodule

// ==== src/uart_link_pkg.sv ====
// uart link package, payload width plus parity and state encodings for the link test
package uart_link_pkg;

    // bits per uart payload
    localparam int DATA_W = 8;

    // parity mode, shared by rx and tx
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,    // 8N1
        PARITY_EVEN = 2'd1,    // 8E1
        PARITY_ODD  = 2'd2     // 8O1
    } parity_mode_e;

    // receiver phases
    typedef enum logic [2:0] {
        RX_IDLE   = 3'd0,      // waiting for falling edge
        RX_START  = 3'd1,      // confirm start bit at mid-bit
        RX_DATA   = 3'd2,      // shift in data, lsb first
        RX_PARITY = 3'd3,      // optional parity bit
        RX_STOP   = 3'd4       // stop sample, flags out
    } rx_state_e;

    // transmitter phases
    typedef enum logic [2:0] {
        TX_IDLE   = 3'd0,
        TX_START  = 3'd1,
        TX_DATA   = 3'd2,
        TX_PARITY = 3'd3,
        TX_STOP   = 3'd4
    } tx_state_e;

    // sequence checker states
    typedef enum logic [1:0] {
        CHK_WAIT    = 2'd0,    // idle until rx_done
        CHK_COMPARE = 2'd1,    // byte vs expected
        CHK_REPORT  = 2'd2     // error count waiting for tx
    } chk_state_e;

endpackage

// ==== include/uart_baud.svh ====
// uart baud presets, clocks per bit for common system clock and baud rate pairs
`ifndef UART_BAUD_SVH
`define UART_BAUD_SVH

// 48 MHz system clock from the on-board oscillator
`define BAUD_1M_CLK48M   48     // 1 Mbaud, exact divide
`define BAUD_115K_CLK48M 417    // 115200 baud, about 0.08% slow

// clocks per bit = f_clk / baud, rounded to nearest
// keep above ~8 so mid-bit sampling has margin

`endif
